// File: filelist.f
logic/pipeline_pkg.sv
logic/ifetch.sv
logic/id.sv
logic/circ_buf.sv
logic/iss.sv
logic/ex_alu.sv
logic/rob.sv
logic/rfile.sv
logic/pipeline.sv
testbench/pipeline_tb.sv

// File: logic/circ_buf.sv
module circ_buf
  import pipeline_pkg::*;
(
  input  logic      clock,
  input  logic      rst,
  input  logic      push,
  input  dec_inst_t push_inst,
  input  logic      pop,
  output dec_inst_t head,
  output logic      empty,
  output logic      full
);

  typedef logic [$clog2(iq_depth)-1:0] ptr_t;
  typedef logic [$clog2(iq_depth):0]   cnt_t;

  dec_inst_t ring [iq_depth];
  ptr_t      hd_ptr;
  ptr_t      tl_ptr;
  cnt_t      used;

  assign head  = ring[hd_ptr];
  assign empty = (used == '0);
  assign full  = (used == cnt_t'(iq_depth));

  always_ff @(posedge clock) begin
    if (push) begin
      ring[tl_ptr] <= push_inst;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clock) begin
    if (rst) begin
      hd_ptr <= '0;
      tl_ptr <= '0;
      used   <= '0;
    end else begin
      if (push) begin
        tl_ptr <= tl_ptr + 1'b1;
      end
      if (pop) begin
        hd_ptr <= hd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

endmodule

// File: logic/ex_alu.sv
module ex_alu
  import pipeline_pkg::*;
(
  input  logic    clock,
  input  logic    rst,
  input  exec_t   exec,
  output result_t result
);

  result_t         stage1;
  logic [xlen-1:0] alu_out;

  always_comb begin
    case (exec.alu_op)
      alu_add: alu_out = exec.a + exec.b;
      alu_sub: alu_out = exec.a - exec.b;
      alu_and: alu_out = exec.a & exec.b;
      alu_or:  alu_out = exec.a | exec.b;
      alu_xor: alu_out = exec.a ^ exec.b;
      alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(exec.a) < $signed(exec.b)};
      default: alu_out = '0;
    endcase
  end

  // Up to two results in flight across the two stages
  always_ff @(posedge clock) begin
    if (rst) begin
      stage1.valid <= 1'b0;
      result.valid <= 1'b0;
    end else begin
      stage1.valid    <= exec.valid;
      stage1.rob_slot <= exec.rob_slot;
      stage1.data     <= alu_out;
      result          <= stage1;
    end
  end

endmodule

// File: logic/id.sv
module id
  import pipeline_pkg::*;
(
  input  fetch_t    fetch,
  input  rob_idx_t  rob_tail,
  input  logic      rob_full,
  input  logic      iq_full,
  output logic      stall,
  output logic      reserve,
  output reg_addr_t reserve_rd,
  output logic      reserve_wr,
  output logic      push,
  output dec_inst_t push_inst
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_imm;
  logic       known;
  alu_op_t    op;

  assign opcode = fetch.inst[6:0];
  assign funct3 = fetch.inst[14:12];
  assign funct7 = fetch.inst[31:25];
  assign is_imm = (opcode == opc_op_imm);

  always_comb begin
    known = 1'b0;
    op    = alu_add;
    if (opcode == opc_op) begin
      known = 1'b1;
      case ({funct7, funct3})
        10'b0000000_000: op = alu_add;
        10'b0100000_000: op = alu_sub;
        10'b0000000_111: op = alu_and;
        10'b0000000_110: op = alu_or;
        10'b0000000_100: op = alu_xor;
        10'b0000000_010: op = alu_slt;
        default:         known = 1'b0;
      endcase
    end else if (is_imm) begin
      known = 1'b1;
      case (funct3)
        3'b000:  op = alu_add;
        3'b111:  op = alu_and;
        3'b110:  op = alu_or;
        3'b100:  op = alu_xor;
        3'b010:  op = alu_slt;
        default: known = 1'b0;
      endcase
    end
  end

  // Back-pressure when either rob or issue queue has no room
  assign stall   = fetch.valid && (rob_full || iq_full);
  assign reserve = fetch.valid && !rob_full && !iq_full;
  assign push    = reserve;

  // Unknown encodings become x0 + 0 with no write
  always_comb begin
    push_inst.pc       = fetch.pc;
    push_inst.alu_op   = op;
    push_inst.rs1      = known ? fetch.inst[19:15] : '0;
    push_inst.rs2      = (known && !is_imm) ? fetch.inst[24:20] : '0;
    push_inst.use_imm  = is_imm || !known;
    push_inst.imm      = known ? {{(xlen-12){fetch.inst[31]}}, fetch.inst[31:20]} : '0;
    push_inst.rd       = known ? fetch.inst[11:7] : '0;
    push_inst.wr       = known && (fetch.inst[11:7] != 5'd0);
    push_inst.rob_slot = rob_tail;
  end

  assign reserve_rd = push_inst.rd;
  assign reserve_wr = push_inst.wr;

endmodule

// File: logic/ifetch.sv
module ifetch
  import pipeline_pkg::*;
(
  input  logic            clock,
  input  logic            rst,
  output logic [xlen-1:0] icache_addr,
  output logic            icache_rd,
  input  logic [31:0]     icache_data,
  input  logic            icache_waitrequest,
  input  logic            stall,
  output fetch_t          fetch
);

  logic [xlen-1:0] pc;
  logic            running;
  logic            accept;

  // Read when the fetch register is empty or id takes it this cycle
  assign icache_rd   = running && (!fetch.valid || !stall);
  assign icache_addr = pc;
  assign accept      = icache_rd && !icache_waitrequest;

  always_ff @(posedge clock) begin
    if (rst) begin
      running     <= 1'b0;
      pc          <= '0;
      fetch.valid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (accept) begin
        pc          <= pc + xlen'(4);
        fetch.valid <= 1'b1;
        fetch.pc    <= pc;
        fetch.inst  <= icache_data;
      end else if (!stall) begin
        // Consumed with nothing new behind it
        fetch.valid <= 1'b0;
      end
    end
  end

endmodule

// File: logic/iss.sv
module iss
  import pipeline_pkg::*;
(
  input  logic            clock,
  input  logic            rst,
  input  dec_inst_t       head,
  input  logic            empty,
  output logic            pop,
  output rob_idx_t        q_slot,
  output reg_addr_t       q_areg,
  output reg_addr_t       q_breg,
  input  logic            a_present,
  input  logic            a_done,
  input  logic [xlen-1:0] a_val,
  input  logic            b_present,
  input  logic            b_done,
  input  logic [xlen-1:0] b_val,
  output reg_addr_t       rd_addr_a,
  output reg_addr_t       rd_addr_b,
  input  logic [xlen-1:0] rd_data_a,
  input  logic [xlen-1:0] rd_data_b,
  output exec_t           exec
);

  logic            a_ready;
  logic            b_ready;
  logic [xlen-1:0] opnd_a;
  logic [xlen-1:0] opnd_b;

  assign q_slot    = head.rob_slot;
  assign q_areg    = head.rs1;
  assign q_breg    = head.rs2;
  assign rd_addr_a = head.rs1;
  assign rd_addr_b = head.rs2;

  // Pending while an older rob entry still owes the value
  assign a_ready = !a_present || a_done;
  assign b_ready = head.use_imm || !b_present || b_done;
  assign pop     = !empty && a_ready && b_ready;

  always_comb begin
    opnd_a = a_present ? a_val : rd_data_a;
    if (head.use_imm) begin
      opnd_b = head.imm;
    end else if (b_present) begin
      opnd_b = b_val;
    end else begin
      opnd_b = rd_data_b;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      exec.valid <= 1'b0;
    end else begin
      exec.valid    <= pop;
      exec.alu_op   <= head.alu_op;
      exec.a        <= opnd_a;
      exec.b        <= opnd_b;
      exec.rob_slot <= head.rob_slot;
    end
  end

endmodule

// File: logic/pipeline.sv
module pipeline
  import pipeline_pkg::*;
(
  input  logic            clock,
  input  logic            rst,
  output logic [xlen-1:0] icache_addr,
  output logic            icache_rd,
  input  logic [31:0]     icache_data,
  input  logic            icache_waitrequest,
  output retire_t         retire
);

  // IF to ID
  fetch_t          if_fetch;

  // ID outputs
  logic            id_stall;
  logic            id_reserve;
  reg_addr_t       id_reserve_rd;
  logic            id_reserve_wr;
  logic            id_push;
  dec_inst_t       id_push_inst;

  // IQ outputs
  dec_inst_t       iq_head;
  logic            iq_empty;
  logic            iq_full;

  // ISS outputs
  logic            iss_pop;
  rob_idx_t        iss_q_slot;
  reg_addr_t       iss_q_areg;
  reg_addr_t       iss_q_breg;
  reg_addr_t       iss_rd_addr_a;
  reg_addr_t       iss_rd_addr_b;
  exec_t           iss_exec;

  // EX and ROB outputs
  result_t         ex_result;
  rob_idx_t        rob_tail;
  logic            rob_full;
  logic            rob_a_present;
  logic            rob_a_done;
  logic [xlen-1:0] rob_a_val;
  logic            rob_b_present;
  logic            rob_b_done;
  logic [xlen-1:0] rob_b_val;
  logic            rob_rf_wr;
  reg_addr_t       rob_rf_wr_addr;
  logic [xlen-1:0] rob_rf_wr_data;

  // Register file reads
  logic [xlen-1:0] rf_rd_data_a;
  logic [xlen-1:0] rf_rd_data_b;

  ifetch IF (
    .clock              (clock),
    .rst                (rst),
    .icache_addr        (icache_addr),
    .icache_rd          (icache_rd),
    .icache_data        (icache_data),
    .icache_waitrequest (icache_waitrequest),
    .stall              (id_stall),
    .fetch              (if_fetch)
  );

  id ID (
    .fetch      (if_fetch),
    .rob_tail   (rob_tail),
    .rob_full   (rob_full),
    .iq_full    (iq_full),
    .stall      (id_stall),
    .reserve    (id_reserve),
    .reserve_rd (id_reserve_rd),
    .reserve_wr (id_reserve_wr),
    .push       (id_push),
    .push_inst  (id_push_inst)
  );

  circ_buf IQ (
    .clock     (clock),
    .rst       (rst),
    .push      (id_push),
    .push_inst (id_push_inst),
    .pop       (iss_pop),
    .head      (iq_head),
    .empty     (iq_empty),
    .full      (iq_full)
  );

  iss ISS (
    .clock     (clock),
    .rst       (rst),
    .head      (iq_head),
    .empty     (iq_empty),
    .pop       (iss_pop),
    .q_slot    (iss_q_slot),
    .q_areg    (iss_q_areg),
    .q_breg    (iss_q_breg),
    .a_present (rob_a_present),
    .a_done    (rob_a_done),
    .a_val     (rob_a_val),
    .b_present (rob_b_present),
    .b_done    (rob_b_done),
    .b_val     (rob_b_val),
    .rd_addr_a (iss_rd_addr_a),
    .rd_addr_b (iss_rd_addr_b),
    .rd_data_a (rf_rd_data_a),
    .rd_data_b (rf_rd_data_b),
    .exec      (iss_exec)
  );

  ex_alu EX (
    .clock  (clock),
    .rst    (rst),
    .exec   (iss_exec),
    .result (ex_result)
  );

  // The pc of the reserved entry comes straight from fetch
  rob ROB (
    .clock      (clock),
    .rst        (rst),
    .reserve    (id_reserve),
    .reserve_rd (id_reserve_rd),
    .reserve_wr (id_reserve_wr),
    .reserve_pc (if_fetch.pc),
    .tail       (rob_tail),
    .full       (rob_full),
    .q_slot     (iss_q_slot),
    .q_areg     (iss_q_areg),
    .q_breg     (iss_q_breg),
    .a_present  (rob_a_present),
    .a_done     (rob_a_done),
    .a_val      (rob_a_val),
    .b_present  (rob_b_present),
    .b_done     (rob_b_done),
    .b_val      (rob_b_val),
    .result     (ex_result),
    .rf_wr      (rob_rf_wr),
    .rf_wr_addr (rob_rf_wr_addr),
    .rf_wr_data (rob_rf_wr_data),
    .retire     (retire)
  );

  rfile REGFILE (
    .clock     (clock),
    .rst       (rst),
    .rd_addr_a (iss_rd_addr_a),
    .rd_addr_b (iss_rd_addr_b),
    .rd_data_a (rf_rd_data_a),
    .rd_data_b (rf_rd_data_b),
    .wr        (rob_rf_wr),
    .wr_addr   (rob_rf_wr_addr),
    .wr_data   (rob_rf_wr_data)
  );

endmodule

// File: logic/pipeline_pkg.sv
package pipeline_pkg;

  localparam int xlen      = 32;
  localparam int rob_depth = 16;
  localparam int iq_depth  = 8;

  // Major opcodes of the integer subset
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;

  typedef logic [4:0]                   reg_addr_t;
  typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
  } fetch_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    alu_op_t         alu_op;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    logic            use_imm;
    logic [xlen-1:0] imm;
    reg_addr_t       rd;
    logic            wr;
    rob_idx_t        rob_slot;
  } dec_inst_t;

  typedef struct packed {
    logic            valid;
    alu_op_t         alu_op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    rob_idx_t        rob_slot;
  } exec_t;

  typedef struct packed {
    logic            valid;
    rob_idx_t        rob_slot;
    logic [xlen-1:0] data;
  } result_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    reg_addr_t       rd;
    logic            wr;
    logic [xlen-1:0] data;
  } retire_t;

endpackage

// File: logic/rfile.sv
module rfile
  import pipeline_pkg::*;
(
  input  logic            clock,
  input  logic            rst,
  input  reg_addr_t       rd_addr_a,
  input  reg_addr_t       rd_addr_b,
  output logic [xlen-1:0] rd_data_a,
  output logic [xlen-1:0] rd_data_b,
  input  logic            wr,
  input  reg_addr_t       wr_addr,
  input  logic [xlen-1:0] wr_data
);

  logic [xlen-1:0] regs [32];

  // x0 reads as zero
  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

// File: logic/rob.sv
module rob
  import pipeline_pkg::*;
(
  input  logic            clock,
  input  logic            rst,
  input  logic            reserve,
  input  reg_addr_t       reserve_rd,
  input  logic            reserve_wr,
  input  logic [xlen-1:0] reserve_pc,
  output rob_idx_t        tail,
  output logic            full,
  input  rob_idx_t        q_slot,
  input  reg_addr_t       q_areg,
  input  reg_addr_t       q_breg,
  output logic            a_present,
  output logic            a_done,
  output logic [xlen-1:0] a_val,
  output logic            b_present,
  output logic            b_done,
  output logic [xlen-1:0] b_val,
  input  result_t         result,
  output logic            rf_wr,
  output reg_addr_t       rf_wr_addr,
  output logic [xlen-1:0] rf_wr_data,
  output retire_t         retire
);

  typedef logic [$clog2(rob_depth):0] cnt_t;

  typedef struct packed {
    logic            present;
    logic            done;
    logic [xlen-1:0] val;
  } lookup_t;

  reg_addr_t       ent_rd   [rob_depth];
  logic            ent_wr   [rob_depth];
  logic [xlen-1:0] ent_pc   [rob_depth];
  logic [xlen-1:0] ent_data [rob_depth];
  logic            ent_done [rob_depth];

  rob_idx_t head;
  cnt_t     count;
  logic     retire_en;
  lookup_t  hit_a;
  lookup_t  hit_b;

  // Youngest writer of r among entries older than q_slot
  function automatic lookup_t lookup(reg_addr_t r);
    lookup_t  hit;
    rob_idx_t idx;
    rob_idx_t age;
    hit = '0;
    age = q_slot - head;
    for (int i = 0; i < rob_depth; i++) begin
      idx = head + rob_idx_t'(i);
      if (i < age && ent_wr[idx] && ent_rd[idx] == r) begin
        hit.present = 1'b1;
        hit.done    = ent_done[idx];
        hit.val     = ent_data[idx];
      end
    end
    return hit;
  endfunction

  always_comb begin
    hit_a = lookup(q_areg);
    hit_b = lookup(q_breg);
  end

  assign a_present = hit_a.present;
  assign a_done    = hit_a.done;
  assign a_val     = hit_a.val;
  assign b_present = hit_b.present;
  assign b_done    = hit_b.done;
  assign b_val     = hit_b.val;

  assign full       = (count == cnt_t'(rob_depth));
  assign retire_en  = (count != '0) && ent_done[head];
  assign rf_wr      = retire_en && ent_wr[head];
  assign rf_wr_addr = ent_rd[head];
  assign rf_wr_data = ent_data[head];

  always_ff @(posedge clock) begin
    if (reserve) begin
      ent_rd[tail] <= reserve_rd;
      ent_wr[tail] <= reserve_wr;
      ent_pc[tail] <= reserve_pc;
    end
    if (result.valid) begin
      ent_data[result.rob_slot] <= result.data;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      retire.valid <= 1'b0;
      for (int i = 0; i < rob_depth; i++) begin
        ent_done[i] <= 1'b0;
      end
    end else begin
      if (reserve) begin
        tail           <= tail + 1'b1;
        ent_done[tail] <= 1'b0;
      end
      if (result.valid) begin
        ent_done[result.rob_slot] <= 1'b1;
      end
      if (retire_en) begin
        head <= head + 1'b1;
      end
      case ({reserve, retire_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Retire port shows data only for register writes
      retire.valid <= retire_en;
      retire.pc    <= ent_pc[head];
      retire.rd    <= ent_rd[head];
      retire.wr    <= ent_wr[head];
      retire.data  <= ent_wr[head] ? ent_data[head] : '0;
    end
  end

endmodule

// File: testbench/pipeline_tb.sv
module pipeline_tb
  import pipeline_pkg::*;
();

  localparam int num_tests      = 6;
  localparam int task_cycles    = 600;
  localparam int timeout_cycles = num_tests * task_cycles + 400;
  localparam int retire_limit   = 500;
  localparam int reset_cycles   = 8;
  localparam int imem_words     = 256;
  localparam logic [31:0] nop_word = 32'h00000013;

  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [6:0] f7_sub = 7'b0100000;

  logic            clock;
  logic            rst;
  logic [xlen-1:0] icache_addr;
  logic            icache_rd;
  logic [31:0]     icache_data;
  logic            icache_waitrequest;
  retire_t         retire;

  logic [31:0] imem [imem_words];
  int          prog_len;
  retire_t     expected [$];
  integer      seed = 9851;
  logic        wait_en;
  int          wait_rnd;
  int          cycle_count;
  int          test_errors;
  int          pass_count;
  int          fail_count;

  pipeline DUT (
    .clock              (clock),
    .rst                (rst),
    .icache_addr        (icache_addr),
    .icache_rd          (icache_rd),
    .icache_data        (icache_data),
    .icache_waitrequest (icache_waitrequest),
    .retire             (retire)
  );

  // Past the end of the program the memory returns ADDI x0,x0,0
  assign icache_data = (int'(icache_addr[31:2]) < prog_len) ? imem[icache_addr[9:2]] : nop_word;

  always #50 clock = ~clock;

  // Wait-state draw on the rising edge, applied on the falling edge
  always @(posedge clock) begin
    wait_rnd = $random(seed);
  end

  always @(negedge clock) begin
    icache_waitrequest = wait_en ? wait_rnd[0] : 1'b0;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Run aborted after %0d cycles without finishing", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  task automatic add_inst(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  // Software model of the 32 registers that builds the retire sequence
  task automatic build_expected();
    logic [31:0] regs [32];
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic        known;
    retire_t     r;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    expected.delete();
    for (int i = 0; i < prog_len; i++) begin
      inst  = imem[i];
      a     = regs[inst[19:15]];
      b     = (inst[6:0] == opc_op) ? regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
      known = 1'b1;
      val   = '0;
      if (inst[6:0] == opc_op && inst[31:25] == f7_sub && inst[14:12] == f3_add) begin
        val = a - b;
      end else if (inst[6:0] == opc_op && inst[31:25] != 7'b0) begin
        known = 1'b0;
      end else if (inst[6:0] != opc_op && inst[6:0] != opc_op_imm) begin
        known = 1'b0;
      end else begin
        case (inst[14:12])
          f3_add:  val = a + b;
          f3_and:  val = a & b;
          f3_or:   val = a | b;
          f3_xor:  val = a ^ b;
          f3_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: known = 1'b0;
        endcase
      end
      r.valid = 1'b1;
      r.pc    = 32'(i) << 2;
      r.rd    = known ? inst[11:7] : 5'd0;
      r.wr    = known && (inst[11:7] != 5'd0);
      r.data  = r.wr ? val : '0;
      if (r.wr) begin
        regs[r.rd] = val;
      end
      expected.push_back(r);
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (reset_cycles) begin
      @(negedge clock);
      if (retire.valid !== 1'b0) begin
        $display("Retire valid was raised during reset");
        test_errors++;
      end
      if (icache_rd !== 1'b0) begin
        $display("Instruction read was raised during reset");
        test_errors++;
      end
    end
    rst = 1'b0;
  endtask

  task automatic compare_retire(input retire_t exp, input int idx);
    if (retire.pc !== exp.pc) begin
      $display("[FAIL] retire.pc #%0d expected %h got %h", idx, exp.pc, retire.pc);
      test_errors++;
    end
    if (retire.rd !== exp.rd) begin
      $display("[FAIL] retire.rd #%0d expected %h got %h", idx, exp.rd, retire.rd);
      test_errors++;
    end
    if (retire.wr !== exp.wr) begin
      $display("[FAIL] retire.wr #%0d expected %h got %h", idx, exp.wr, retire.wr);
      test_errors++;
    end
    if (retire.data !== exp.data) begin
      $display("[FAIL] retire.data #%0d expected %h got %h", idx, exp.data, retire.data);
      test_errors++;
    end
  endtask

  // Reset, then compare each retirement with the model in order
  task automatic run_program(input string name);
    int retired;
    int waited;
    build_expected();
    apply_reset();
    retired = 0;
    waited  = 0;
    while (retired < expected.size() && waited < retire_limit) begin
      @(negedge clock);
      waited++;
      if (retire.valid === 1'b1) begin
        compare_retire(expected[retired], retired);
        retired++;
      end
    end
    if (retired < expected.size()) begin
      $display("Only %0d of %0d instructions retired", retired, expected.size());
      test_errors++;
    end
    report_test(name, retired);
  endtask

  task automatic report_test(input string name, input int retired);
    if (test_errors == 0) begin
      pass_count++;
      $display("PASS  %s (%0d retired)", name, retired);
    end else begin
      fail_count++;
      $display("FAIL  %s (%0d errors)", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic test_reset_fetch();
    int waited;
    prog_len = 0;
    apply_reset();
    waited = 0;
    while (icache_rd !== 1'b1 && waited < 20) begin
      @(negedge clock);
      waited++;
      if (retire.valid !== 1'b0) begin
        $display("Retire valid seen before the first instruction read");
        test_errors++;
      end
    end
    if (icache_rd !== 1'b1) begin
      $display("No instruction read started within 20 cycles of reset");
      test_errors++;
    end else if (icache_addr !== 32'h0) begin
      $display("[FAIL] icache_addr expected %h got %h", 32'h0, icache_addr);
      test_errors++;
    end
    report_test("reset and first fetch", 0);
  endtask

  task automatic test_independent();
    prog_len = 0;
    add_inst(i_type(f3_add, 5'd1, 5'd0, 12'd100));
    add_inst(i_type(f3_add, 5'd2, 5'd0, 12'hff9));
    add_inst(i_type(f3_add, 5'd3, 5'd0, 12'h7ff));
    add_inst(i_type(f3_xor, 5'd4, 5'd0, 12'hfff));
    add_inst(i_type(f3_or, 5'd5, 5'd0, 12'h055));
    add_inst(i_type(f3_and, 5'd6, 5'd0, 12'h03c));
    add_inst(i_type(f3_slt, 5'd7, 5'd0, 12'd1));
    add_inst(r_type(7'd0, f3_add, 5'd8, 5'd1, 5'd2));
    add_inst(r_type(f7_sub, f3_add, 5'd9, 5'd3, 5'd1));
    add_inst(r_type(7'd0, f3_and, 5'd10, 5'd4, 5'd5));
    add_inst(r_type(7'd0, f3_or, 5'd11, 5'd5, 5'd3));
    add_inst(r_type(7'd0, f3_xor, 5'd12, 5'd1, 5'd3));
    add_inst(r_type(7'd0, f3_slt, 5'd13, 5'd2, 5'd1));
    add_inst(r_type(7'd0, f3_slt, 5'd14, 5'd1, 5'd2));
    run_program("independent ALU and immediate ops");
  endtask

  task automatic test_dependent();
    prog_len = 0;
    add_inst(i_type(f3_add, 5'd1, 5'd0, 12'd1));
    add_inst(r_type(7'd0, f3_add, 5'd1, 5'd1, 5'd1));
    add_inst(r_type(7'd0, f3_add, 5'd1, 5'd1, 5'd1));
    add_inst(i_type(f3_add, 5'd2, 5'd1, 12'd3));
    add_inst(r_type(f7_sub, f3_add, 5'd3, 5'd2, 5'd1));
    add_inst(r_type(7'd0, f3_xor, 5'd4, 5'd3, 5'd2));
    add_inst(r_type(7'd0, f3_slt, 5'd5, 5'd4, 5'd3));
    add_inst(r_type(7'd0, f3_or, 5'd6, 5'd5, 5'd4));
    add_inst(r_type(7'd0, f3_and, 5'd7, 5'd6, 5'd2));
    add_inst(i_type(f3_add, 5'd7, 5'd7, 12'hfff));
    add_inst(i_type(f3_slt, 5'd8, 5'd7, 12'd5));
    add_inst(i_type(f3_xor, 5'd9, 5'd8, 12'h800));
    add_inst(r_type(f7_sub, f3_add, 5'd10, 5'd9, 5'd9));
    run_program("back-to-back dependent chains");
  endtask

  task automatic test_x0_and_unknown();
    prog_len = 0;
    add_inst(i_type(f3_add, 5'd1, 5'd0, 12'd9));
    add_inst(i_type(f3_add, 5'd0, 5'd0, 12'd5));
    add_inst(r_type(7'd0, f3_add, 5'd0, 5'd1, 5'd1));
    add_inst(32'hffffffff);
    add_inst(32'h00000000);
    // OR with a bad funct7 and a shift lie outside the subset
    add_inst(r_type(f7_sub, f3_or, 5'd2, 5'd1, 5'd1));
    add_inst(i_type(3'b001, 5'd2, 5'd1, 12'd1));
    add_inst(r_type(7'd0, f3_add, 5'd3, 5'd0, 5'd1));
    add_inst(r_type(7'd0, f3_or, 5'd5, 5'd0, 5'd0));
    add_inst(r_type(f7_sub, f3_add, 5'd6, 5'd1, 5'd0));
    add_inst(r_type(7'd0, f3_add, 5'd7, 5'd2, 5'd0));
    run_program("x0 writes and unknown encodings");
  endtask

  task automatic test_random();
    int         pick;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm;
    prog_len = 0;
    for (int i = 0; i < 40; i++) begin
      pick = ($random(seed) & 32'h7fffffff) % 11;
      rd   = 5'(($random(seed) & 32'h7fffffff) % 8);
      rs1  = 5'(($random(seed) & 32'h7fffffff) % 8);
      rs2  = 5'(($random(seed) & 32'h7fffffff) % 8);
      imm  = 12'($random(seed));
      case (pick)
        0:  add_inst(r_type(7'd0, f3_add, rd, rs1, rs2));
        1:  add_inst(r_type(f7_sub, f3_add, rd, rs1, rs2));
        2:  add_inst(r_type(7'd0, f3_and, rd, rs1, rs2));
        3:  add_inst(r_type(7'd0, f3_or, rd, rs1, rs2));
        4:  add_inst(r_type(7'd0, f3_xor, rd, rs1, rs2));
        5:  add_inst(r_type(7'd0, f3_slt, rd, rs1, rs2));
        6:  add_inst(i_type(f3_add, rd, rs1, imm));
        7:  add_inst(i_type(f3_and, rd, rs1, imm));
        8:  add_inst(i_type(f3_or, rd, rs1, imm));
        9:  add_inst(i_type(f3_xor, rd, rs1, imm));
        default: add_inst(i_type(f3_slt, rd, rs1, imm));
      endcase
    end
    wait_en = 1'b1;
    run_program("random program with wait states");
    wait_en = 1'b0;
  endtask

  // Long chain on x1 holds the queue head while fetch fills rob and queue
  task automatic test_overfill();
    prog_len = 0;
    for (int i = 0; i < 30; i++) begin
      case (i % 3)
        0:       add_inst(i_type(f3_add, 5'd1, 5'd1, 12'(i + 1)));
        1:       add_inst(r_type(7'd0, f3_add, 5'd1, 5'd1, 5'd1));
        default: add_inst(i_type(f3_xor, 5'd1, 5'd1, 12'h5a5));
      endcase
    end
    for (int j = 0; j < 20; j++) begin
      add_inst(i_type(f3_add, 5'(2 + j % 6), 5'd0, 12'(j * 7)));
    end
    run_program("issue queue and rob overfill");
  endtask

  initial begin
    clock              = 1'b0;
    rst                = 1'b1;
    icache_waitrequest = 1'b0;
    wait_en            = 1'b0;
    prog_len           = 0;
    cycle_count        = 0;
    test_errors        = 0;
    pass_count         = 0;
    fail_count         = 0;
    test_reset_fetch();
    test_independent();
    test_dependent();
    test_x0_and_unknown();
    test_random();
    test_overfill();
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
